//--- hdl/vga_timing_pkg.sv
package vga_timing_pkg;

	////////////////////////////////////////
	// horizontal geometry, in pixel clocks
	localparam int h_total        = 800;
	localparam int h_sync_len     = 96;
	localparam int h_active_start = 144;
	localparam int h_active_len   = 640;

	////////////////////////////////////////
	// vertical geometry, in lines
	localparam int v_total        = 525;
	localparam int v_sync_len     = 2;
	localparam int v_active_start = 35;
	localparam int v_active_len   = 480;
	// first line of the bottom blanking
	localparam int v_blank_start  = 515;

	// counter and coordinate widths
	localparam int h_count_w = 10;
	localparam int v_count_w = 10;
	localparam int col_w     = 10;
	localparam int row_w     = 9;

endpackage

//--- hdl/trace_pkg.sv
package trace_pkg;

	////////////////////////////////////////
	// captured sample, one byte
	// high nibble whole volts, low nibble tenths
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [3:0] volts;
			logic [3:0] tenths;
		} bcd;
	} sample_t;

	////////////////////////////////////////
	// band geometry
	localparam int band_w      = 5;
	localparam int band_count  = 18;
	localparam int band_height = 13;

	// first row of each half, active coordinates
	localparam int top_base    = 0;
	localparam int bottom_base = 246;

	// white line across the middle
	localparam int divider_first = 235;
	localparam int divider_last  = 240;

	////////////////////////////////////////
	// column entry, msb first:
	// top_valid, top_band, bottom_valid, bottom_band
	localparam int entry_w          = 12;
	localparam int top_valid_bit    = 11;
	localparam int top_band_lsb     = 6;
	localparam int bottom_valid_bit = 5;
	localparam int bottom_band_lsb  = 0;

	// colours as {red, green, blue}, two bits each
	localparam logic [5:0] trace_colour   = 6'b001100;
	localparam logic [5:0] divider_colour = 6'b111111;
	localparam logic [5:0] blank_colour   = 6'b000000;

endpackage

//--- hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
	input  logic                             clk_25MHz,
	input  logic                             rst,
	output logic [vga_timing_pkg::col_w-1:0] col,
	output logic [vga_timing_pkg::row_w-1:0] row,
	output logic                             active,
	output logic                             h_sync_raw,
	output logic                             v_sync_raw,
	output logic                             frame_tick
);
	import vga_timing_pkg::*;

	logic [h_count_w-1:0] h_count;
	logic [v_count_w-1:0] v_count;
	logic                 h_in_window;
	logic                 v_in_window;

	////////////////////////////////////////
	// pixel and line counters
	always_ff @(posedge clk_25MHz)
	begin
		if (rst)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else if (h_count == h_count_w'(h_total - 1))
		begin
			h_count <= '0;
			if (v_count == v_count_w'(v_total - 1))
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end
		else
		begin
			h_count <= h_count + 1'b1;
		end
	end

	////////////////////////////////////////
	// decode of the current counter state
	always_comb
	begin
		h_sync_raw  = (h_count < h_sync_len);
		v_sync_raw  = (v_count < v_sync_len);
		h_in_window = (h_count >= h_active_start) &&
			(h_count < h_active_start + h_active_len);
		v_in_window = (v_count >= v_active_start) && (v_count < v_blank_start);
		active      = h_in_window && v_in_window;
		// wraps outside the window, consumers gate on active
		col         = col_w'(h_count - h_active_start);
		row         = row_w'(v_count - v_active_start);
		// start of the bottom blanking, once per frame
		frame_tick  = (v_count == v_count_w'(v_blank_start)) && (h_count == '0);
	end

	// counters must wrap before their totals
	counters_in_range: assert property (@(posedge clk_25MHz) disable iff (rst)
		(h_count < h_total) && (v_count < v_total));

endmodule

//--- hdl/sample_mapper.sv
`timescale 1ns/1ps

module sample_mapper (
	input  logic                          clk_25MHz,
	input  logic                          rst,
	input  logic                          frame_tick,
	input  trace_pkg::sample_t            signal_data,
	input  logic [1:0]                    mode,
	output logic [trace_pkg::entry_w-1:0] entry,
	output logic                          entry_wr
);
	import trace_pkg::*;

	sample_t           sample_q;
	logic [1:0]        mode_q;
	logic [3:0]        volts;
	logic [1:0]        sub;
	logic [band_w-1:0] band;
	logic              top_valid;
	logic              bottom_valid;

	// capture once per frame
	always_ff @(posedge clk_25MHz)
	begin
		if (frame_tick)
		begin
			sample_q.raw <= signal_data.raw;
			mode_q       <= mode;
		end
	end

	// write strobe one cycle behind the capture
	always_ff @(posedge clk_25MHz)
	begin
		if (rst)
			entry_wr <= 1'b0;
		else
			entry_wr <= frame_tick;
	end

	////////////////////////////////////////
	// band rule, 5 volts at the top of a half
	always_comb
	begin
		// out of range readings draw as 0 volts
		if (sample_q.bcd.volts > 4'd5)
			volts = 4'd0;
		else
			volts = sample_q.bcd.volts;

		// three bands per volt, high tenths nearest the top
		if (sample_q.bcd.tenths > 4'd6)
			sub = 2'd0;
		else if (sample_q.bcd.tenths >= 4'd4)
			sub = 2'd1;
		else
			sub = 2'd2;

		band = band_w'((4'd5 - volts) * 3 + sub);

		// mode 3 leaves both halves empty
		top_valid    = (mode_q == 2'd0) || (mode_q == 2'd2);
		bottom_valid = (mode_q == 2'd1) || (mode_q == 2'd2);

		entry                                = '0;
		entry[top_valid_bit]                 = top_valid;
		entry[top_band_lsb +: band_w]        = band;
		entry[bottom_valid_bit]              = bottom_valid;
		entry[bottom_band_lsb +: band_w]     = band;
	end

endmodule

//--- hdl/trace_column_store.sv
`timescale 1ns/1ps

module trace_column_store (
	input  logic                               clk_25MHz,
	input  logic                               rst,
	input  logic [trace_pkg::entry_w-1:0]      entry,
	input  logic                               entry_wr,
	input  logic [vga_timing_pkg::col_w-1:0]   col,
	output logic [trace_pkg::entry_w-1:0]      rd_entry
);
	import vga_timing_pkg::*;
	import trace_pkg::*;

	logic [entry_w-1:0] mem [h_active_len];

	logic [col_w-1:0]   clr_addr;
	logic [col_w-1:0]   wr_col;
	logic [col_w-1:0]   rd_addr;
	logic               ready;

	logic               we;
	logic [col_w-1:0]   waddr;
	logic [entry_w-1:0] wdata;

	////////////////////////////////////////
	// clear sweep and scrolling write column
	always_ff @(posedge clk_25MHz)
	begin
		if (rst)
		begin
			clr_addr <= '0;
			wr_col   <= '0;
			ready    <= 1'b0;
		end
		else if (!ready)
		begin
			if (clr_addr == col_w'(h_active_len - 1))
				ready <= 1'b1;
			else
				clr_addr <= clr_addr + 1'b1;
		end
		else if (entry_wr)
		begin
			if (wr_col == col_w'(h_active_len - 1))
				wr_col <= '0;
			else
				wr_col <= wr_col + 1'b1;
		end
	end

	// single write port shared by sweep and trace updates
	always_comb
	begin
		we    = !ready || entry_wr;
		waddr = ready ? wr_col : clr_addr;
		wdata = ready ? entry : '0;
		// blanking columns fall outside the buffer
		rd_addr = (col < h_active_len) ? col : '0;
	end

	////////////////////////////////////////
	// buffer with registered read
	always_ff @(posedge clk_25MHz)
	begin
		if (we)
			mem[waddr] <= wdata;
		rd_entry <= mem[rd_addr];
	end

	// trace writes come only in blanking, after the sweep
	no_write_in_sweep: assert property (@(posedge clk_25MHz) disable iff (rst)
		entry_wr |-> ready);

endmodule

//--- hdl/pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader (
	input  logic                             clk_25MHz,
	input  logic                             rst,
	input  logic [trace_pkg::entry_w-1:0]    rd_entry,
	input  logic [vga_timing_pkg::row_w-1:0] row,
	input  logic                             active,
	input  logic                             h_sync_raw,
	input  logic                             v_sync_raw,
	output logic [1:0]                       red,
	output logic [1:0]                       green,
	output logic [1:0]                       blue,
	output logic                             hsync,
	output logic                             vsync
);
	import vga_timing_pkg::*;
	import trace_pkg::*;

	logic [row_w-1:0]  row_d;
	logic              active_d;
	logic              hs_d;
	logic              vs_d;

	logic [band_w-1:0] top_band;
	logic [band_w-1:0] bottom_band;
	logic [row_w-1:0]  top_start;
	logic [row_w-1:0]  bottom_start;
	logic              top_hit;
	logic              bottom_hit;
	logic              divider_hit;
	logic [5:0]        pix_colour;

	////////////////////////////////////////
	// line up with the buffer read
	always_ff @(posedge clk_25MHz)
	begin
		row_d <= row;
		if (rst)
		begin
			active_d <= 1'b0;
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
		end
		else
		begin
			active_d <= active;
			hs_d     <= h_sync_raw;
			vs_d     <= v_sync_raw;
		end
	end

	always_comb
	begin
		top_band     = rd_entry[top_band_lsb +: band_w];
		bottom_band  = rd_entry[bottom_band_lsb +: band_w];
		top_start    = row_w'(top_base + top_band * band_height);
		bottom_start = row_w'(bottom_base + bottom_band * band_height);
		// band fields beyond the last band draw nothing
		top_hit      = rd_entry[top_valid_bit] && (top_band < band_count) &&
			(row_d >= top_start) && (row_d < top_start + band_height);
		bottom_hit   = rd_entry[bottom_valid_bit] && (bottom_band < band_count) &&
			(row_d >= bottom_start) && (row_d < bottom_start + band_height);
		divider_hit  = (row_d >= divider_first) && (row_d <= divider_last);

		if (!active_d)
			pix_colour = blank_colour;
		else if (divider_hit)
			pix_colour = divider_colour;
		else if (top_hit || bottom_hit)
			pix_colour = trace_colour;
		else
			pix_colour = blank_colour;
	end

	////////////////////////////////////////
	// registered outputs to the connector
	always_ff @(posedge clk_25MHz)
	begin
		if (rst)
		begin
			{red, green, blue} <= 6'b000000;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			{red, green, blue} <= pix_colour;
			hsync <= hs_d;
			vsync <= vs_d;
		end
	end

	// nothing lit outside the visible window
	dark_outside: assert property (@(posedge clk_25MHz) disable iff (rst)
		!active_d |=> (red == 2'b00) && (green == 2'b00) && (blue == 2'b00));

endmodule

//--- hdl/scope_display_top.sv
`timescale 1ns/1ps

module scope_display_top (
	input  logic               clk_25MHz,
	input  logic               rst,
	input  trace_pkg::sample_t signal_data,
	input  logic [1:0]         mode,
	output logic               hsync,
	output logic               vsync,
	output logic [1:0]         red,
	output logic [1:0]         green,
	output logic [1:0]         blue
);
	import vga_timing_pkg::*;
	import trace_pkg::*;

	// timing to the rest of the pipe
	logic [col_w-1:0]   col;
	logic [row_w-1:0]   row;
	logic               active;
	logic               h_sync_raw;
	logic               v_sync_raw;
	logic               frame_tick;

	// column update and readback
	logic [entry_w-1:0] entry;
	logic               entry_wr;
	logic [entry_w-1:0] rd_entry;

	vga_timing u_timing (
		.clk_25MHz  (clk_25MHz),
		.rst        (rst),
		.col        (col),
		.row        (row),
		.active     (active),
		.h_sync_raw (h_sync_raw),
		.v_sync_raw (v_sync_raw),
		.frame_tick (frame_tick)
	);

	sample_mapper u_mapper (
		.clk_25MHz   (clk_25MHz),
		.rst         (rst),
		.frame_tick  (frame_tick),
		.signal_data (signal_data),
		.mode        (mode),
		.entry       (entry),
		.entry_wr    (entry_wr)
	);

	trace_column_store u_store (
		.clk_25MHz (clk_25MHz),
		.rst       (rst),
		.entry     (entry),
		.entry_wr  (entry_wr),
		.col       (col),
		.rd_entry  (rd_entry)
	);

	pixel_shader u_shader (
		.clk_25MHz  (clk_25MHz),
		.rst        (rst),
		.rd_entry   (rd_entry),
		.row        (row),
		.active     (active),
		.h_sync_raw (h_sync_raw),
		.v_sync_raw (v_sync_raw),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.hsync      (hsync),
		.vsync      (vsync)
	);

endmodule

//--- sim/scope_display_tb.sv
`timescale 1ns/1ps

module scope_display_tb;
	import trace_pkg::*;

	// screen geometry as seen from the connector
	localparam int line_cycles  = 800;
	localparam int frame_lines  = 525;
	localparam int hs_cycles    = 96;
	localparam int vs_lines     = 2;
	localparam int first_col_h  = 144;
	localparam int first_row_v  = 35;
	localparam int frame_cycles = line_cycles * frame_lines;

	// trace drawing rules
	localparam int rows_per_band = 13;
	localparam int lower_half_row = 246;
	localparam logic [5:0] green_px = 6'b001100;
	localparam logic [5:0] white_px = 6'b111111;
	localparam logic [5:0] black_px = 6'b000000;

	localparam int reset_cycles = 5;
	localparam int run_frames   = 8;
	// two extra cycles to see the last position at the outputs
	localparam int run_cycles   = run_frames * frame_cycles + 2;
	localparam int cycle_limit  = 9 * frame_cycles;

	logic       clk_25MHz;
	logic       rst;
	sample_t    signal_data;
	logic [1:0] mode;
	logic       hsync;
	logic       vsync;
	logic [1:0] red;
	logic [1:0] green;
	logic [1:0] blue;

	integer     seed;
	int         pos_h;
	int         pos_v;
	int         pos_frame;
	sample_t    hist_sample [run_frames];
	logic [1:0] hist_mode [run_frames];

	scope_display_top UUT (
		.clk_25MHz   (clk_25MHz),
		.rst         (rst),
		.signal_data (signal_data),
		.mode        (mode),
		.hsync       (hsync),
		.vsync       (vsync),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

	initial
	begin
		clk_25MHz = 1'b0;
		forever #20 clk_25MHz = ~clk_25MHz;
	end

	////////////////////////////////////////
	// reference model and compare tasks
	function automatic logic [5:0] expected_colour(input int row, input int col,
		input int frames_done);
		int volts;
		int tenths;
		int sub;
		int band_row;
		logic [5:0] colour;
		colour = black_px;
		if (row >= 0 && row < 480 && col >= 0 && col < 640)
		begin
			if (row >= 235 && row <= 240)
				colour = white_px;
			else if (col < frames_done)
			begin
				// column k holds the sample of frame k
				volts  = hist_sample[col].raw[7:4];
				tenths = hist_sample[col].raw[3:0];
				if (volts > 5)
					volts = 0;
				if (tenths > 6)
					sub = 0;
				else if (tenths >= 4)
					sub = 1;
				else
					sub = 2;
				band_row = ((5 - volts) * 3 + sub) * rows_per_band;
				if ((hist_mode[col] == 2'd0 || hist_mode[col] == 2'd2) &&
					row >= band_row && row < band_row + rows_per_band)
					colour = green_px;
				if ((hist_mode[col] == 2'd1 || hist_mode[col] == 2'd2) &&
					row >= lower_half_row + band_row &&
					row < lower_half_row + band_row + rows_per_band)
					colour = green_px;
			end
		end
		return colour;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_colour(input logic [1:0] red_got, input logic [1:0] green_got,
		input logic [1:0] blue_got, input logic [5:0] rgb_exp);
		if ({red_got, green_got, blue_got} !== rgb_exp)
		begin
			$display("Mismatch at %0t: red/green/blue got %b/%b/%b expected %b/%b/%b",
				$time, red_got, green_got, blue_got,
				rgb_exp[5:4], rgb_exp[3:2], rgb_exp[1:0]);
			abort_run("pixel colour differs from the reference");
		end
	endtask

	task automatic check_sync(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run("sync output differs from the reference");
		end
	endtask

	////////////////////////////////////////
	// stimulus helpers
	task automatic advance_position();
		pos_h = pos_h + 1;
		if (pos_h == line_cycles)
		begin
			pos_h = 0;
			pos_v = pos_v + 1;
			if (pos_v == frame_lines)
			begin
				pos_v = 0;
				pos_frame = pos_frame + 1;
			end
		end
	endtask

	// covers volts 0..7 with every tenths class and all modes
	task automatic drive_scripted_sample(input int k);
		case (k)
			0: {mode, signal_data.raw} = {2'd0, 8'h59};
			1: {mode, signal_data.raw} = {2'd1, 8'h33};
			2: {mode, signal_data.raw} = {2'd2, 8'h64};
			3: {mode, signal_data.raw} = {2'd1, 8'h06};
			4: {mode, signal_data.raw} = {2'd2, 8'h47};
			5: {mode, signal_data.raw} = {2'd0, 8'h70};
			6: {mode, signal_data.raw} = {2'd3, 8'h13};
			default: {mode, signal_data.raw} = {2'd2, 8'h26};
		endcase
		hist_sample[k] = signal_data;
		hist_mode[k]   = mode;
	endtask

	// noise after the capture that must not reach the display
	task automatic drive_random_sample();
		logic [31:0] rnd;
		rnd = $random(seed);
		signal_data.raw = rnd[7:0];
		mode = rnd[9:8];
	endtask

	initial
	begin
		int n;
		$timeformat(-9, 0, " ns", 0);
		seed = 32'h07de3691;
		rst = 1'b1;
		signal_data.raw = 8'h00;
		mode = 2'd0;
		pos_h = 0;
		pos_v = 0;
		pos_frame = 0;
		repeat (reset_cycles) @(posedge clk_25MHz);
		#5;
		rst = 1'b0;
		for (n = 0; n < run_cycles; n++)
		begin
			if (n > 0)
			begin
				@(posedge clk_25MHz);
				#5;
				advance_position();
			end
			if (pos_h == 0 && pos_v == 240)
				drive_scripted_sample(pos_frame);
			else if (pos_h == 0 && pos_v == 520)
				drive_random_sample();
		end
		// let the checker see the last position
		@(negedge clk_25MHz);
		#1;
		$display("*** PASSED ***");
		$finish;
	end

	////////////////////////////////////////
	// output checker running two cycles behind the counters
	initial
	begin
		int since_release;
		int h1, v1, f1;
		int h2, v2, f2;
		logic [5:0] rgb_exp;
		since_release = 0;
		@(posedge clk_25MHz);
		forever
		begin
			@(negedge clk_25MHz);
			if (rst || since_release < 2)
			begin
				check_colour(red, green, blue, black_px);
				check_sync("hsync", hsync, 1'b0);
				check_sync("vsync", vsync, 1'b0);
			end
			else
			begin
				rgb_exp = expected_colour(v2 - first_row_v, h2 - first_col_h, f2);
				check_colour(red, green, blue, rgb_exp);
				check_sync("hsync", hsync, h2 < hs_cycles);
				check_sync("vsync", vsync, v2 < vs_lines);
			end
			if (!rst)
			begin
				h2 = h1;
				v2 = v1;
				f2 = f1;
				h1 = pos_h;
				v1 = pos_v;
				f1 = pos_frame;
				since_release = since_release + 1;
			end
		end
	end

	// run length limit
	initial
	begin
		int cycles;
		cycles = 0;
		forever
		begin
			@(posedge clk_25MHz);
			cycles = cycles + 1;
			if (cycles >= cycle_limit)
				abort_run("timeout: the run did not finish within the cycle limit");
		end
	end

endmodule

//--- scope_display.f
hdl/vga_timing_pkg.sv
hdl/trace_pkg.sv
hdl/vga_timing.sv
hdl/sample_mapper.sv
hdl/trace_column_store.sv
hdl/pixel_shader.sv
hdl/scope_display_top.sv
sim/scope_display_tb.sv
